//--- cmp_pkg.sv
`default_nettype none

package cmp_pkg;

    // datapath width of the core
    localparam int xlen_c = 32;

    // default number of station entries
    localparam int rs_size_c = 6;

    // lanes on the common data bus
    localparam int cdb_lanes_c = 2;

    // rob index, tag 0 means no tag
    typedef logic [3:0] rob_tag_t;

    typedef logic [xlen_c-1:0] word_t;

    typedef logic [2:0] cmp_op_t;

    // branch codes follow funct3, slt and sltu fill the two free codes
    localparam cmp_op_t cmp_beq_c  = 3'b000;
    localparam cmp_op_t cmp_bne_c  = 3'b001;
    localparam cmp_op_t cmp_slt_c  = 3'b010;
    localparam cmp_op_t cmp_sltu_c = 3'b011;
    localparam cmp_op_t cmp_blt_c  = 3'b100;
    localparam cmp_op_t cmp_bge_c  = 3'b101;
    localparam cmp_op_t cmp_bltu_c = 3'b110;
    localparam cmp_op_t cmp_bgeu_c = 3'b111;

    // source operand, either waiting on tag or holding value
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

    // one compare instruction from dispatch
    typedef struct packed {
        logic     valid;
        cmp_op_t  op;
        logic     br;
        rob_tag_t rob_idx;
        word_t    pc;
        word_t    b_imm;
        operand_t rs1;
        operand_t rs2;
    } cmp_dispatch_t;

    // one lane of the common data bus
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
        word_t    target_pc;
    } cdb_entry_t;

    // lane 0 external producer, lane 1 compare results
    typedef cdb_entry_t [cdb_lanes_c-1:0] cdb_t;

endpackage

`default_nettype wire

//--- cmp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cmp_unit (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             load_i,
    input  cmp_pkg::cmp_op_t op_i,
    input  cmp_pkg::word_t   a_i,
    input  cmp_pkg::word_t   b_i,
    output logic             f_o,
    output logic             ready_o
);
    import cmp_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic f_next;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (op_i)
            cmp_beq_c:  f_next = eq;
            cmp_bne_c:  f_next = !eq;
            cmp_blt_c,
            cmp_slt_c:  f_next = lt_s;
            cmp_bge_c:  f_next = !lt_s;
            cmp_bltu_c,
            cmp_sltu_c: f_next = lt_u;
            cmp_bgeu_c: f_next = !lt_u;
            default:    f_next = 1'b0;
        endcase
    end

    // result held until the next load
    always_ff @(posedge clk) begin
        if (load_i) begin
            f_o <= f_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= load_i;
        end
    end

    // all eight codes are in use, so only an unknown opcode is undefined
    a_op_defined: assert property (@(posedge clk) disable iff (rst_i)
        load_i |-> !$isunknown(op_i))
        else $error("cmp_unit: load with undefined opcode %b", op_i);

endmodule

`default_nettype wire

//--- rob_result_store.sv
`timescale 1ns/1ps
`default_nettype none

module rob_result_store (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  flush_i,
    // port 0 from tag alloc, port 1 from compare dispatch
    input  logic [1:0]                            clr_valid_i,
    input  cmp_pkg::rob_tag_t [1:0]               clr_tag_i,
    input  cmp_pkg::cdb_t                         cdb_i,
    input  cmp_pkg::rob_tag_t                     rd1_tag_i,
    input  cmp_pkg::rob_tag_t                     rd2_tag_i,
    output logic                                  rd1_done_o,
    output cmp_pkg::word_t                        rd1_value_o,
    output logic                                  rd2_done_o,
    output cmp_pkg::word_t                        rd2_value_o
);
    import cmp_pkg::*;

    localparam int NUM_TAGS = 2 ** $bits(rob_tag_t);

    logic [NUM_TAGS-1:0] done_q;
    word_t               value_q [NUM_TAGS];

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            done_q <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (clr_valid_i[k]) begin
                    done_q[clr_tag_i[k]] <= 1'b0;
                end
            end
            // broadcast after clear so a completion is never lost
            for (int j = 0; j < cdb_lanes_c; j++) begin
                if (cdb_i[j].valid) begin
                    done_q[cdb_i[j].tag] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < cdb_lanes_c; j++) begin
            if (cdb_i[j].valid) begin
                value_q[cdb_i[j].tag] <= cdb_i[j].value;
            end
        end
    end

    // reads see a broadcast in the same cycle
    always_comb begin
        rd1_done_o  = done_q[rd1_tag_i];
        rd1_value_o = value_q[rd1_tag_i];
        rd2_done_o  = done_q[rd2_tag_i];
        rd2_value_o = value_q[rd2_tag_i];
        for (int j = 0; j < cdb_lanes_c; j++) begin
            if (cdb_i[j].valid && cdb_i[j].tag == rd1_tag_i) begin
                rd1_done_o  = 1'b1;
                rd1_value_o = cdb_i[j].value;
            end
            if (cdb_i[j].valid && cdb_i[j].tag == rd2_tag_i) begin
                rd2_done_o  = 1'b1;
                rd2_value_o = cdb_i[j].value;
            end
        end
    end

    // each tag is owned by one producer, so the lanes never collide
    a_lane_tags_distinct: assert property (@(posedge clk) disable iff (rst_i)
        cdb_i[0].valid && cdb_i[1].valid |-> cdb_i[0].tag != cdb_i[1].tag)
        else $error("rob_result_store: both cdb lanes carry tag %0d", cdb_i[0].tag);

endmodule

`default_nettype wire

//--- cmp_rs.sv
`timescale 1ns/1ps
`default_nettype none

module cmp_rs #(
    parameter int RS_SIZE = cmp_pkg::rs_size_c
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              flush_i,
    input  cmp_pkg::cmp_dispatch_t            disp_i,
    input  cmp_pkg::cdb_t                     cdb_i,
    output cmp_pkg::rob_tag_t                 rob_rd1_tag_o,
    input  logic                              rob_rd1_done_i,
    input  cmp_pkg::word_t                    rob_rd1_value_i,
    output cmp_pkg::rob_tag_t                 rob_rd2_tag_o,
    input  logic                              rob_rd2_done_i,
    input  cmp_pkg::word_t                    rob_rd2_value_i,
    output logic                              rs_full_o,
    output cmp_pkg::cdb_entry_t [RS_SIZE-1:0] done_o
);
    import cmp_pkg::*;

    localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

    cmp_dispatch_t      ent_q [RS_SIZE];
    logic [RS_SIZE-1:0] busy_q;
    logic [RS_SIZE-1:0] issued_q;
    logic [RS_SIZE-1:0] load_cmp_q;
    logic [RS_SIZE-1:0] cmp_f;
    logic [RS_SIZE-1:0] cmp_rdy;
    logic               cmp_rst;
    logic [IDX_W-1:0]   free_idx;
    logic               disp_accept;
    cmp_dispatch_t      disp_res;

    // take the value from the result store if the producer is done
    function automatic operand_t from_store(operand_t op, logic done, word_t value);
        operand_t r;
        r = op;
        if (!op.valid && done) begin
            r.valid = 1'b1;
            r.value = value;
        end
        return r;
    endfunction

    // capture from either cdb lane on tag match
    function automatic operand_t snoop(operand_t op, cdb_t cdb);
        operand_t r;
        r = op;
        for (int j = 0; j < cdb_lanes_c; j++) begin
            if (!op.valid && cdb[j].valid && cdb[j].tag == op.tag) begin
                r.valid = 1'b1;
                r.value = cdb[j].value;
            end
        end
        return r;
    endfunction

    assign rs_full_o     = &busy_q;
    assign disp_accept   = disp_i.valid && !rs_full_o;
    assign rob_rd1_tag_o = disp_i.rs1.tag;
    assign rob_rd2_tag_o = disp_i.rs2.tag;
    assign cmp_rst       = rst_i || flush_i;

    // lowest free entry
    always_comb begin
        free_idx = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    // store lookup also covers a same-cycle broadcast on either lane
    always_comb begin
        disp_res     = disp_i;
        disp_res.rs1 = from_store(disp_i.rs1, rob_rd1_done_i, rob_rd1_value_i);
        disp_res.rs2 = from_store(disp_i.rs2, rob_rd2_done_i, rob_rd2_value_i);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (busy_q[i]) begin
                ent_q[i].rs1 <= snoop(ent_q[i].rs1, cdb_i);
                ent_q[i].rs2 <= snoop(ent_q[i].rs2, cdb_i);
            end
        end
        if (disp_accept) begin
            ent_q[free_idx] <= disp_res;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            busy_q     <= '0;
            issued_q   <= '0;
            load_cmp_q <= '0;
        end else begin
            for (int i = 0; i < RS_SIZE; i++) begin
                load_cmp_q[i] <= 1'b0;
                // one strobe per entry once both operands are in
                if (busy_q[i] && !issued_q[i] && ent_q[i].rs1.valid && ent_q[i].rs2.valid) begin
                    load_cmp_q[i] <= 1'b1;
                    issued_q[i]   <= 1'b1;
                end
                if (busy_q[i] && cmp_rdy[i]) begin
                    busy_q[i]   <= 1'b0;
                    issued_q[i] <= 1'b0;
                end
            end
            if (disp_accept) begin
                busy_q[free_idx]   <= 1'b1;
                issued_q[free_idx] <= 1'b0;
            end
        end
    end

    // packet leaves in the cycle the comparator reports ready
    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            done_o[i]       = '0;
            done_o[i].valid = busy_q[i] && cmp_rdy[i];
            done_o[i].tag   = ent_q[i].rob_idx;
            done_o[i].value = {{(xlen_c - 1){1'b0}}, cmp_f[i]};
            if (ent_q[i].br) begin
                done_o[i].target_pc = cmp_f[i] ? ent_q[i].pc + ent_q[i].b_imm
                                               : ent_q[i].pc + word_t'(4);
            end
        end
    end

    for (genvar g = 0; g < RS_SIZE; g++) begin : gen_cmp
        cmp_unit cmp_unit_i (
            .clk     (clk),
            .rst_i   (cmp_rst),
            .load_i  (load_cmp_q[g]),
            .op_i    (ent_q[g].op),
            .a_i     (ent_q[g].rs1.value),
            .b_i     (ent_q[g].rs2.value),
            .f_o     (cmp_f[g]),
            .ready_o (cmp_rdy[g])
        );

        // a waiting operand must name a real producer
        a_wait_tag: assert property (@(posedge clk) disable iff (rst_i)
            busy_q[g] |-> (ent_q[g].rs1.valid || ent_q[g].rs1.tag != '0) &&
                          (ent_q[g].rs2.valid || ent_q[g].rs2.tag != '0))
            else $error("cmp_rs: entry %0d waits on tag 0", g);
    end

    a_no_disp_full: assert property (@(posedge clk) disable iff (rst_i)
        disp_i.valid |-> !rs_full_o)
        else $error("cmp_rs: dispatch while station full");

endmodule

`default_nettype wire

//--- cmp_cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cmp_cdb_arbiter #(
    parameter int RS_SIZE = cmp_pkg::rs_size_c
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              flush_i,
    input  cmp_pkg::cdb_entry_t [RS_SIZE-1:0] done_i,
    output cmp_pkg::cdb_entry_t               cdb_o
);
    import cmp_pkg::*;

    localparam int PTR_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;
    localparam int CNT_W = $clog2(RS_SIZE + 1);

    cdb_entry_t       queue_q [RS_SIZE];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] push_cnt;
    logic [PTR_W-1:0] slot [RS_SIZE];
    logic             pop;

    // circular add, n never exceeds RS_SIZE
    function automatic logic [PTR_W-1:0] ptr_add(logic [PTR_W-1:0] ptr, int n);
        int sum;
        sum = int'(ptr) + n;
        if (sum >= RS_SIZE) begin
            sum = sum - RS_SIZE;
        end
        return PTR_W'(sum);
    endfunction

    // valid inputs take consecutive slots in index order
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            slot[i] = ptr_add(wr_ptr_q, int'(push_cnt));
            if (done_i[i].valid) begin
                push_cnt = push_cnt + 1'b1;
            end
        end
    end

    assign pop   = (count_q != '0);
    assign cdb_o = pop ? queue_q[rd_ptr_q] : '0;

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (done_i[i].valid) begin
                queue_q[slot[i]] <= done_i[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= ptr_add(wr_ptr_q, int'(push_cnt));
            rd_ptr_q <= pop ? ptr_add(rd_ptr_q, 1) : rd_ptr_q;
            count_q  <= count_q + push_cnt - CNT_W'(pop);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst_i || flush_i)
        int'(count_q) + int'(push_cnt) - int'(pop) <= RS_SIZE)
        else $error("cmp_cdb_arbiter: queue overflow, count %0d push %0d", count_q, push_cnt);

endmodule

`default_nettype wire

//--- cmp_cluster_top.sv
`timescale 1ns/1ps
`default_nettype none

module cmp_cluster_top #(
    parameter int RS_SIZE = cmp_pkg::rs_size_c
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  cmp_pkg::cmp_dispatch_t disp_i,
    input  logic                   alloc_valid_i,
    input  cmp_pkg::rob_tag_t      alloc_tag_i,
    input  cmp_pkg::cdb_entry_t    ext_cdb_i,
    output logic                   rs_full_o,
    output cmp_pkg::cdb_t          cdb_o
);
    import cmp_pkg::*;

    cdb_entry_t [RS_SIZE-1:0] rs_done;
    rob_tag_t                 rd1_tag;
    rob_tag_t                 rd2_tag;
    logic                     rd1_done;
    logic                     rd2_done;
    word_t                    rd1_value;
    word_t                    rd2_value;

    // lane 0 straight from the outside producer
    assign cdb_o[0] = ext_cdb_i;

    cmp_rs #(
        .RS_SIZE (RS_SIZE)
    ) cmp_rs_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .flush_i         (flush_i),
        .disp_i          (disp_i),
        .cdb_i           (cdb_o),
        .rob_rd1_tag_o   (rd1_tag),
        .rob_rd1_done_i  (rd1_done),
        .rob_rd1_value_i (rd1_value),
        .rob_rd2_tag_o   (rd2_tag),
        .rob_rd2_done_i  (rd2_done),
        .rob_rd2_value_i (rd2_value),
        .rs_full_o       (rs_full_o),
        .done_o          (rs_done)
    );

    // alloc and compare dispatch both retire the old result of a tag
    rob_result_store rob_result_store_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .clr_valid_i ({disp_i.valid, alloc_valid_i}),
        .clr_tag_i   ({disp_i.rob_idx, alloc_tag_i}),
        .cdb_i       (cdb_o),
        .rd1_tag_i   (rd1_tag),
        .rd2_tag_i   (rd2_tag),
        .rd1_done_o  (rd1_done),
        .rd1_value_o (rd1_value),
        .rd2_done_o  (rd2_done),
        .rd2_value_o (rd2_value)
    );

    cmp_cdb_arbiter #(
        .RS_SIZE (RS_SIZE)
    ) cmp_cdb_arbiter_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .done_i  (rs_done),
        .cdb_o   (cdb_o[1])
    );

endmodule

`default_nettype wire

//--- tb_cmp_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cmp_cluster;
    import cmp_pkg::*;

    logic          clk;
    logic          rst_i;
    logic          flush_i;
    cmp_dispatch_t disp_i;
    logic          alloc_valid_i;
    rob_tag_t      alloc_tag_i;
    cdb_entry_t    ext_cdb_i;
    logic          rs_full_o;
    cdb_t          cdb_o;

    // state per producer tag 1..7 (0 free, 1 waiting for its result, 2 result sent)
    int            prod_state [16];
    word_t         prod_val [16];
    int            prod_refs [16];
    // compare tags 8..15
    logic          cmp_busy [16];
    cmp_dispatch_t cmp_rec [16];
    int            outstanding;
    // traffic mode (0 idle, 1 random traffic, 2 drain, 3 fill behind a held producer)
    int            mode;
    logic          hold_tag;
    int            hold_p;

    cmp_cluster_top #(
        .RS_SIZE (rs_size_c)
    ) cmp_cluster_top_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .disp_i        (disp_i),
        .alloc_valid_i (alloc_valid_i),
        .alloc_tag_i   (alloc_tag_i),
        .ext_cdb_i     (ext_cdb_i),
        .rs_full_o     (rs_full_o),
        .cdb_o         (cdb_o)
    );

    always #2 clk = ~clk;

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped at the first failed check");
    endtask

    // slt and sltu share the signed and unsigned less-than rules
    function automatic logic expected_flag(cmp_op_t op, word_t a, word_t b);
        logic r;
        case (op)
            cmp_beq_c:              r = (a == b);
            cmp_bne_c:              r = (a != b);
            cmp_blt_c, cmp_slt_c:   r = ($signed(a) < $signed(b));
            cmp_bge_c:              r = ($signed(a) >= $signed(b));
            cmp_bltu_c, cmp_sltu_c: r = (a < b);
            default:                r = (a >= b);
        endcase
        return r;
    endfunction

    // small and near-negative values make equal operands likely
    function automatic word_t rand_word();
        word_t w;
        case ($urandom % 4)
            0:       w = word_t'($urandom % 4);
            1:       w = 32'hffff_fffe + word_t'($urandom % 3);
            default: w = word_t'($urandom);
        endcase
        return w;
    endfunction

    // want 0 also takes a finished tag that nothing reads any more
    function automatic int pick_prod(int want, int avoid);
        int s;
        int p;
        s = $urandom % 7;
        for (int k = 0; k < 7; k++) begin
            p = 1 + (s + k) % 7;
            if (p != avoid && !(hold_tag && p == hold_p) && (prod_state[p] == want ||
                    (want == 0 && prod_state[p] == 2 && prod_refs[p] == 0))) begin
                return p;
            end
        end
        return 0;
    endfunction

    function automatic int pick_cmp_tag();
        int s;
        s = $urandom % 8;
        for (int k = 0; k < 8; k++) begin
            if (!cmp_busy[8 + (s + k) % 8]) begin
                return 8 + (s + k) % 8;
            end
        end
        return 0;
    endfunction

    // ready, done in the store, broadcast this cycle, or broadcast later
    function automatic operand_t make_operand(int p_now, int p_new);
        operand_t o;
        int       p;
        o.valid = 1'b1;
        o.tag   = '0;
        o.value = rand_word();
        case ($urandom % 4)
            0:       p = pick_prod(2, p_new);
            1:       p = p_now;
            2:       p = pick_prod(1, p_new);
            default: p = 0;
        endcase
        if (hold_tag) begin
            p = hold_p;
        end
        if (p != 0) begin
            o.valid = 1'b0;
            o.tag   = rob_tag_t'(p);
            o.value = '0;
            prod_refs[p]++;
        end
        return o;
    endfunction

    function automatic word_t operand_value(operand_t o);
        return o.valid ? o.value : prod_val[o.tag];
    endfunction

    function automatic void release_refs(cmp_dispatch_t r);
        if (!r.rs1.valid) begin
            prod_refs[r.rs1.tag]--;
        end
        if (!r.rs2.valid) begin
            prod_refs[r.rs2.tag]--;
        end
    endfunction

    function automatic int count_pending();
        int n;
        n = 0;
        for (int p = 1; p < 8; p++) begin
            if (prod_state[p] == 1) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic clear_inputs();
        flush_i       = 1'b0;
        alloc_valid_i = 1'b0;
        alloc_tag_i   = '0;
        ext_cdb_i     = '0;
        disp_i        = '0;
    endtask

    task automatic reset_model();
        for (int i = 0; i < 16; i++) begin
            prod_state[i] = 0;
            prod_refs[i]  = 0;
            cmp_busy[i]   = 1'b0;
        end
        outstanding = 0;
        hold_tag    = 1'b0;
    endtask

    // lane 0 passes the producer result through unchanged
    task automatic check_lane0();
        assert (cdb_o[0] == ext_cdb_i)
            else stop_run($sformatf("error at %0t: lane 0 %h, expected %h",
                $time, cdb_o[0], ext_cdb_i));
    endtask

    task automatic check_lane1();
        cdb_entry_t    c;
        cmp_dispatch_t r;
        logic          f;
        word_t         pc_exp;
        c = cdb_o[1];
        if (c.valid) begin
            assert (c.tag >= 4'd8 && cmp_busy[c.tag])
                else stop_run($sformatf("lane 1 carried tag %0d with no compare in flight",
                    c.tag));
            r      = cmp_rec[c.tag];
            f      = expected_flag(r.op, operand_value(r.rs1), operand_value(r.rs2));
            pc_exp = f ? r.pc + r.b_imm : r.pc + 32'd4;
            assert (c.value == word_t'(f))
                else stop_run($sformatf("error at %0t: tag %0d op %0d value %0h, expected %0h",
                    $time, c.tag, r.op, c.value, f));
            if (r.br) begin
                assert (c.target_pc == pc_exp)
                    else stop_run($sformatf("error at %0t: tag %0d target %h, expected %h",
                        $time, c.tag, c.target_pc, pc_exp));
            end
            cmp_busy[c.tag] = 1'b0;
            release_refs(r);
            outstanding--;
        end
    endtask

    task automatic drive_cycle();
        int            p_done;
        int            p_new;
        int            t;
        cmp_dispatch_t d;
        @(negedge clk);
        check_lane0();
        check_lane1();
        clear_inputs();
        p_done = 0;
        p_new  = 0;
        if (mode != 0 && $urandom % 3 == 0) begin
            p_done = pick_prod(1, 0);
        end
        if (p_done != 0) begin
            prod_val[p_done]   = rand_word();
            prod_state[p_done] = 2;
            ext_cdb_i.valid    = 1'b1;
            ext_cdb_i.tag      = rob_tag_t'(p_done);
            ext_cdb_i.value    = prod_val[p_done];
        end else if (mode == 1 && $urandom % 2 == 0) begin
            p_new = pick_prod(0, 0);
            if (p_new != 0) begin
                prod_state[p_new] = 1;
                alloc_valid_i     = 1'b1;
                alloc_tag_i       = rob_tag_t'(p_new);
            end
        end
        t = pick_cmp_tag();
        if ((mode == 1 || mode == 3) && !rs_full_o && t != 0 && $urandom % 2 == 0) begin
            d           = '0;
            d.valid     = 1'b1;
            d.op        = cmp_op_t'($urandom % 8);
            d.br        = !(d.op == cmp_slt_c || d.op == cmp_sltu_c);
            d.rob_idx   = rob_tag_t'(t);
            d.pc        = word_t'($urandom) & 32'hffff_fffc;
            d.b_imm     = (word_t'($urandom % 8192) - 32'd4096) & 32'hffff_fffe;
            d.rs1       = make_operand(p_done, p_new);
            d.rs2       = make_operand(p_done, p_new);
            cmp_rec[t]  = d;
            cmp_busy[t] = 1'b1;
            outstanding++;
            disp_i      = d;
        end
    endtask

    task automatic run_cycles(int n);
        repeat (n) drive_cycle();
    endtask

    task automatic drain();
        int n;
        mode = 2;
        n    = 0;
        while (outstanding != 0 || count_pending() != 0) begin
            assert (n < 500) else stop_run("timeout while waiting for results to drain");
            drive_cycle();
            n++;
        end
    endtask

    // fill every entry behind one held producer and optionally release it
    task automatic fill_station(logic release_held);
        int   n;
        logic seen_free;
        hold_p = pick_prod(0, 0);
        assert (hold_p != 0) else stop_run("no free producer tag for the fill test");
        @(negedge clk);
        check_lane0();
        check_lane1();
        clear_inputs();
        alloc_valid_i      = 1'b1;
        alloc_tag_i        = rob_tag_t'(hold_p);
        prod_state[hold_p] = 1;
        hold_tag           = 1'b1;
        mode               = 3;
        n                  = 0;
        while (!rs_full_o) begin
            assert (n < 200) else stop_run("timeout while waiting for rs_full_o to rise");
            drive_cycle();
            n++;
        end
        assert (outstanding == rs_size_c)
            else stop_run("rs_full_o rose before every entry was taken");
        if (release_held) begin
            hold_tag  = 1'b0;
            mode      = 2;
            seen_free = 1'b0;
            n         = 0;
            while (outstanding != 0) begin
                assert (n < 200)
                    else stop_run("timeout while waiting for the full station to empty");
                drive_cycle();
                seen_free = seen_free || !rs_full_o;
                n++;
            end
            assert (seen_free && !rs_full_o)
                else stop_run("rs_full_o stayed high after results left");
        end
    endtask

    task automatic drive_flush();
        @(negedge clk);
        check_lane0();
        check_lane1();
        clear_inputs();
        flush_i = 1'b1;
        reset_model();
    endtask

    initial begin
        void'($urandom(32'h2c41d14f));
        clk    = 1'b0;
        rst_i  = 1'b1;
        mode   = 0;
        hold_p = 0;
        clear_inputs();
        reset_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        assert (!rs_full_o && !cdb_o[1].valid)
            else stop_run("rs_full_o or lane 1 valid was set right after reset");
        mode = 1;
        run_cycles(400);
        drain();
        fill_station(1'b1);
        mode = 1;
        run_cycles(40);
        drive_flush();
        // nothing may leave lane 1 for the flushed compares
        mode = 0;
        run_cycles(10);
        mode = 1;
        run_cycles(100);
        drain();
        // a full station is flushed before its held producer is released
        fill_station(1'b0);
        drive_flush();
        mode = 0;
        run_cycles(10);
        assert (!rs_full_o) else stop_run("station still full after flush");
        mode = 1;
        run_cycles(300);
        drain();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
cmp_pkg.sv
cmp_unit.sv
rob_result_store.sv
cmp_rs.sv
cmp_cdb_arbiter.sv
cmp_cluster_top.sv
tb_cmp_cluster.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cmp_cluster
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
